// File: hdl/mcu_ctrl_cfg.svh
`ifndef MCU_CTRL_CFG_SVH
`define MCU_CTRL_CFG_SVH

// Instruction fields
`define MCU_OP_W     6
`define MCU_FUNCT_W  6

// Datapath select widths
`define MCU_ALUOP_W  3
`define MCU_PCSRC_W  3
`define MCU_IORD_W   2

// Memory address select codes for the two exception vectors
`define MCU_IORD_VEC_ILLEGAL  2'd2
`define MCU_IORD_VEC_DIVZERO  2'd3

`endif

// File: hdl/isa_pkg.sv
`include "mcu_ctrl_cfg.svh"

package isa_pkg;

    // Primary opcodes kept in this core
    typedef enum logic [`MCU_OP_W-1:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // R-type funct field
    typedef enum logic [`MCU_FUNCT_W-1:0] {
        fn_mult = 6'h18,
        fn_div  = 6'h1a,
        fn_add  = 6'h20,
        fn_sub  = 6'h22,
        fn_and  = 6'h24
    } funct_t;

    typedef enum logic [3:0] {
        cls_alu_r,
        cls_alu_i,
        cls_branch,
        cls_load,
        cls_store,
        cls_jump,
        cls_mult,
        cls_div,
        cls_illegal
    } instr_class_t;

endpackage

// File: hdl/ctrl_pkg.sv
`include "mcu_ctrl_cfg.svh"

package ctrl_pkg;

    // All 32 codes are in use
    typedef enum logic [4:0] {
        st_fetch1, st_fetch2, st_decode1, st_decode2,
        st_add, st_sub, st_and, st_addi,
        st_wb_rd, st_wb_rt,
        st_branch, st_jump,
        st_ld_addr, st_ld_read, st_ld_wait, st_ld_mdr, st_ld_wb,
        st_st_addr, st_st_write, st_st_wait,
        st_mult_start, st_mult_wait, st_mult_hilo,
        st_div_start, st_div_wait, st_div_hilo,
        st_exc_epc, st_exc_vec_ill, st_exc_vec_dz,
        st_exc_wait, st_exc_mdr, st_exc_pc
    } state_t;

    typedef enum logic [`MCU_ALUOP_W-1:0] {
        alu_pass = 3'b000,
        alu_add  = 3'b001,
        alu_sub  = 3'b010,
        alu_and  = 3'b011,
        alu_cmp  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        src_b_reg_b, src_b_four, src_b_imm, src_b_imm_shifted
    } alu_src_b_t;

    typedef enum logic [`MCU_PCSRC_W-1:0] {
        pc_alu_result  = 3'b000,
        pc_alu_out     = 3'b001,
        pc_jump_target = 3'b010,
        pc_mdr_vector  = 3'b110
    } pc_src_t;

    typedef enum logic [`MCU_IORD_W-1:0] {
        addr_pc          = 2'd0,
        addr_alu_out     = 2'd1,
        addr_vec_illegal = `MCU_IORD_VEC_ILLEGAL,
        addr_vec_divzero = `MCU_IORD_VEC_DIVZERO
    } mem_addr_t;

    typedef enum logic {dst_rt, dst_rd} reg_dst_t;
    typedef enum logic {m2r_alu_out, m2r_mdr} mem_to_reg_t;
    typedef enum logic {br_eq, br_ne} branch_op_t;

endpackage

// File: hdl/instr_decoder.sv
`include "mcu_ctrl_cfg.svh"

module instr_decoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic [`MCU_OP_W-1:0]    opcode,
    input  logic [`MCU_FUNCT_W-1:0] funct,
    output instr_class_t            instr_class,
    output branch_op_t              branch_op
);

    always_comb begin
        instr_class = cls_illegal; // Anything not listed traps
        branch_op   = br_eq;
        case (opcode)
            op_rtype: begin
                case (funct)
                    fn_add,
                    fn_sub,
                    fn_and:  instr_class = cls_alu_r;
                    fn_mult: instr_class = cls_mult;
                    fn_div:  instr_class = cls_div;
                    default: instr_class = cls_illegal;
                endcase
            end
            op_addi: instr_class = cls_alu_i;
            op_beq:  instr_class = cls_branch;
            op_bne: begin
                instr_class = cls_branch;
                branch_op   = br_ne;
            end
            op_lw:   instr_class = cls_load;
            op_sw:   instr_class = cls_store;
            op_j:    instr_class = cls_jump;
            default: instr_class = cls_illegal;
        endcase
    end

endmodule

// File: hdl/main_sequencer.sv
module main_sequencer
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instr_class_t instr_class,
    input  funct_t       alu_func,
    input  logic         div_zero,
    input  logic         div_done,
    input  logic         mult_done,
    output state_t       state
);

    state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = st_fetch1; // Last state of every path
        case (state)
            st_fetch1:  next_state = st_fetch2;
            st_fetch2:  next_state = st_decode1;
            st_decode1: next_state = st_decode2;
            st_decode2: begin
                case (instr_class)
                    cls_alu_r: begin
                        case (alu_func)
                            fn_add:  next_state = st_add;
                            fn_sub:  next_state = st_sub;
                            fn_and:  next_state = st_and;
                            default: next_state = st_exc_epc;
                        endcase
                    end
                    cls_alu_i:  next_state = st_addi;
                    cls_branch: next_state = st_branch;
                    cls_load:   next_state = st_ld_addr;
                    cls_store:  next_state = st_st_addr;
                    cls_jump:   next_state = st_jump;
                    cls_mult:   next_state = st_mult_start;
                    cls_div:    next_state = st_div_start;
                    default:    next_state = st_exc_epc;
                endcase
            end
            st_add,
            st_sub,
            st_and:      next_state = st_wb_rd;
            st_addi:     next_state = st_wb_rt;
            st_ld_addr:  next_state = st_ld_read;
            st_ld_read:  next_state = st_ld_wait;
            st_ld_wait:  next_state = st_ld_mdr;
            st_ld_mdr:   next_state = st_ld_wb;
            st_st_addr:  next_state = st_st_write;
            st_st_write: next_state = st_st_wait;
            st_mult_start: next_state = st_mult_wait;
            st_mult_wait: begin
                next_state = mult_done ? st_mult_hilo : st_mult_wait;
            end
            st_div_start: next_state = st_div_wait;
            st_div_wait: begin
                if (div_zero) begin // Zero divisor beats done
                    next_state = st_exc_epc;
                end else if (div_done) begin
                    next_state = st_div_hilo;
                end else begin
                    next_state = st_div_wait;
                end
            end
            // Only the divide trap arrives here with a div class held
            st_exc_epc: begin
                next_state = (instr_class == cls_div) ? st_exc_vec_dz : st_exc_vec_ill;
            end
            st_exc_vec_ill,
            st_exc_vec_dz: next_state = st_exc_wait;
            st_exc_wait:   next_state = st_exc_mdr;
            st_exc_mdr:    next_state = st_exc_pc;
            default:       next_state = st_fetch1;
        endcase
    end

    state_known_a: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(state)
    );

    // Divider handshake is held until a flag arrives
    div_wait_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        (state == st_div_wait && !div_done && !div_zero) |=> (state == st_div_wait)
    );

endmodule

// File: hdl/datapath_ctrl_encoder.sv
module datapath_ctrl_encoder
    import ctrl_pkg::*;
(
    input  state_t      state,
    input  branch_op_t  branch_sel,
    output alu_op_t     alu_op,
    output logic        alu_src_a,
    output alu_src_b_t  alu_src_b,
    output pc_src_t     pc_source,
    output mem_addr_t   mem_addr,
    output reg_dst_t    reg_dst,
    output mem_to_reg_t mem_to_reg,
    output branch_op_t  branch_op,
    output logic        hilo_sel,
    output logic        pc_write,
    output logic        pc_write_cond,
    output logic        ir_load,
    output logic        ab_load,
    output logic        alu_out_load,
    output logic        mem_write,
    output logic        mdr_load,
    output logic        reg_write,
    output logic        hilo_load,
    output logic        epc_load,
    output logic        mult_start,
    output logic        div_start
);

    always_comb begin
        alu_op        = alu_pass;
        alu_src_a     = 1'b0; // PC
        alu_src_b     = src_b_reg_b;
        pc_source     = pc_alu_result;
        mem_addr      = addr_pc;
        reg_dst       = dst_rt;
        mem_to_reg    = m2r_alu_out;
        branch_op     = br_eq;
        hilo_sel      = 1'b0;
        pc_write      = 1'b0;
        pc_write_cond = 1'b0;
        ir_load       = 1'b0;
        ab_load       = 1'b0;
        alu_out_load  = 1'b0;
        mem_write     = 1'b0;
        mdr_load      = 1'b0;
        reg_write     = 1'b0;
        hilo_load     = 1'b0;
        epc_load      = 1'b0;
        mult_start    = 1'b0;
        div_start     = 1'b0;
        case (state)
            st_fetch2: begin // PC + 4
                alu_src_b = src_b_four;
                alu_op    = alu_add;
                pc_write  = 1'b1;
            end
            st_decode1: ir_load = 1'b1;
            st_decode2: begin
                // Branch target lands in ALUOut early
                alu_src_b    = src_b_imm_shifted;
                alu_op       = alu_add;
                ab_load      = 1'b1;
                alu_out_load = 1'b1;
            end
            st_add,
            st_sub,
            st_and: begin
                alu_src_a    = 1'b1;
                alu_op       = (state == st_add) ? alu_add :
                               (state == st_sub) ? alu_sub : alu_and;
                alu_out_load = 1'b1;
            end
            st_addi,
            st_ld_addr,
            st_st_addr: begin // A + sign-extended immediate
                alu_src_a    = 1'b1;
                alu_src_b    = src_b_imm;
                alu_op       = alu_add;
                alu_out_load = 1'b1;
            end
            st_wb_rd: begin
                reg_dst   = dst_rd;
                reg_write = 1'b1;
            end
            st_wb_rt:   reg_write = 1'b1;
            st_branch: begin
                alu_src_a     = 1'b1;
                alu_op        = alu_cmp;
                pc_source     = pc_alu_out;
                branch_op     = branch_sel;
                pc_write_cond = 1'b1;
            end
            st_jump: begin
                pc_source = pc_jump_target;
                pc_write  = 1'b1;
            end
            st_ld_read,
            st_ld_wait: mem_addr = addr_alu_out;
            st_ld_mdr: begin
                mem_addr = addr_alu_out;
                mdr_load = 1'b1;
            end
            st_ld_wb: begin
                mem_to_reg = m2r_mdr;
                reg_write  = 1'b1;
            end
            st_st_write: begin
                mem_addr  = addr_alu_out;
                mem_write = 1'b1;
            end
            st_mult_start: mult_start = 1'b1;
            st_div_start:  div_start  = 1'b1;
            st_mult_hilo: begin
                hilo_sel  = 1'b1;
                hilo_load = 1'b1;
            end
            st_div_hilo:   hilo_load  = 1'b1;
            st_exc_epc: begin // EPC gets PC - 4
                alu_src_b = src_b_four;
                alu_op    = alu_sub;
                epc_load  = 1'b1;
            end
            st_exc_vec_ill: mem_addr = addr_vec_illegal;
            st_exc_vec_dz:  mem_addr = addr_vec_divzero;
            st_exc_mdr: begin
                pc_source = pc_mdr_vector;
                mdr_load  = 1'b1;
            end
            st_exc_pc: begin
                pc_source = pc_mdr_vector;
                pc_write  = 1'b1;
            end
            default: ;
        endcase

        reg_mem_excl_a: assert (!(reg_write && mem_write));
        start_excl_a: assert (!(mult_start && div_start));
    end

endmodule

// File: hdl/mcu_ctrl_top.sv
`include "mcu_ctrl_cfg.svh"

module mcu_ctrl_top
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MCU_OP_W-1:0]    opcode,
    input  logic [`MCU_FUNCT_W-1:0] funct,
    input  logic                    div_zero,
    input  logic                    div_done,
    input  logic                    mult_done,
    output alu_op_t                 alu_op,
    output logic                    alu_src_a,
    output alu_src_b_t              alu_src_b,
    output pc_src_t                 pc_source,
    output mem_addr_t               mem_addr,
    output reg_dst_t                reg_dst,
    output mem_to_reg_t             mem_to_reg,
    output branch_op_t              branch_op,
    output logic                    hilo_sel,
    output logic                    pc_write,
    output logic                    pc_write_cond,
    output logic                    ir_load,
    output logic                    ab_load,
    output logic                    alu_out_load,
    output logic                    mem_write,
    output logic                    mdr_load,
    output logic                    reg_write,
    output logic                    hilo_load,
    output logic                    epc_load,
    output logic                    mult_start,
    output logic                    div_start
);

    instr_class_t instr_class;
    branch_op_t   branch_sel;
    state_t       state;

    instr_decoder u_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class),
        .branch_op   (branch_sel)
    );

    main_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .alu_func    (funct_t'(funct)),
        .div_zero    (div_zero),
        .div_done    (div_done),
        .mult_done   (mult_done),
        .state       (state)
    );

    datapath_ctrl_encoder u_encoder (
        .state         (state),
        .branch_sel    (branch_sel),
        .alu_op        (alu_op),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .pc_source     (pc_source),
        .mem_addr      (mem_addr),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .branch_op     (branch_op),
        .hilo_sel      (hilo_sel),
        .pc_write      (pc_write),
        .pc_write_cond (pc_write_cond),
        .ir_load       (ir_load),
        .ab_load       (ab_load),
        .alu_out_load  (alu_out_load),
        .mem_write     (mem_write),
        .mdr_load      (mdr_load),
        .reg_write     (reg_write),
        .hilo_load     (hilo_load),
        .epc_load      (epc_load),
        .mult_start    (mult_start),
        .div_start     (div_start)
    );

endmodule

// File: tb/mcu_ctrl_tests.svh
// Fetch and decode strobes shared by every instruction
task automatic expect_common();
    int c;
    for (c = 0; c < 64; c++) begin
        exp_strobes[c] = '0;
    end
    exp_strobes[2][sb_pc_write]     = 1'b1;
    exp_strobes[3][sb_ir_load]      = 1'b1;
    exp_strobes[4][sb_ab_load]      = 1'b1;
    exp_strobes[4][sb_alu_out_load] = 1'b1;
endtask

task automatic test_reset();
    int i;
    reset_dut();
    sample_outputs(1);
    for (i = 0; i < 12; i++) begin
        compare_strobe({strobe_names[i], " after reset"}, 1'b0, strobe_log[1][i]);
    end
    compare_mem_addr("mem_addr after reset", addr_pc, addr_log[1]);
endtask

task automatic check_alu_r(input funct_t fn, input alu_op_t op);
    run_instr(op_rtype, fn, 0, 0, 0);
    expect_common();
    exp_strobes[5][sb_alu_out_load] = 1'b1;
    exp_strobes[6][sb_reg_write]    = 1'b1;
    check_run(6);
    compare_alu_op("alu_op in exec", op, alu_log[5]);
    compare_strobe("alu_src_a in exec", 1'b1, srca_log[5]);
    compare_reg_dst("reg_dst in writeback", dst_rd, dst_log[6]);
    compare_mem_to_reg("mem_to_reg in writeback", m2r_alu_out, m2r_log[6]);
endtask

task automatic test_alu_r();
    check_alu_r(fn_add, alu_add);
    check_alu_r(fn_sub, alu_sub);
    check_alu_r(fn_and, alu_and);
endtask

task automatic test_addi();
    run_instr(op_addi, 6'h00, 0, 0, 0);
    expect_common();
    exp_strobes[5][sb_alu_out_load] = 1'b1;
    exp_strobes[6][sb_reg_write]    = 1'b1;
    check_run(6);
    compare_alu_op("alu_op in addi exec", alu_add, alu_log[5]);
    compare_strobe("alu_src_a in addi exec", 1'b1, srca_log[5]);
    compare_src_b("alu_src_b in addi exec", src_b_imm, src_b_log[5]);
    compare_reg_dst("reg_dst in addi writeback", dst_rt, dst_log[6]);
endtask

task automatic check_branch(input opcode_t op, input branch_op_t br);
    run_instr(op, 6'h00, 0, 0, 0);
    expect_common();
    exp_strobes[5][sb_pc_write_cond] = 1'b1; // reg_write stays low through all cycles
    check_run(5);
    compare_strobe("alu_src_a in branch", 1'b1, srca_log[5]);
    compare_pc_src("pc_source in branch", pc_alu_out, pc_log[5]);
    compare_branch_op("branch_op in branch", br, br_log[5]);
endtask

task automatic test_branch();
    check_branch(op_beq, br_eq);
    check_branch(op_bne, br_ne);
endtask

task automatic test_jump();
    run_instr(op_j, 6'h00, 0, 0, 0);
    expect_common();
    exp_strobes[5][sb_pc_write] = 1'b1;
    check_run(5);
    compare_pc_src("pc_source in jump", pc_jump_target, pc_log[5]);
endtask

task automatic test_load();
    run_instr(op_lw, 6'h00, 0, 0, 0);
    expect_common();
    exp_strobes[5][sb_alu_out_load] = 1'b1;
    exp_strobes[8][sb_mdr_load]     = 1'b1;
    exp_strobes[9][sb_reg_write]    = 1'b1;
    check_run(9);
    compare_mem_addr("mem_addr in load read", addr_alu_out, addr_log[6]);
    compare_mem_to_reg("mem_to_reg in load writeback", m2r_mdr, m2r_log[9]);
    compare_reg_dst("reg_dst in load writeback", dst_rt, dst_log[9]);
endtask

task automatic test_store();
    run_instr(op_sw, 6'h00, 0, 0, 0);
    expect_common();
    exp_strobes[5][sb_alu_out_load] = 1'b1;
    exp_strobes[6][sb_mem_write]    = 1'b1;
    check_run(7);
    compare_mem_addr("mem_addr in store write", addr_alu_out, addr_log[6]);
endtask

// Done arrives after n wait cycles, HI/LO loads on the next cycle
task automatic check_muldiv(input funct_t fn, input strobe_idx_t start, input logic sel);
    int n;
    n = $unsigned($random(seed)) % 16;
    if (fn == fn_mult)
        run_instr(op_rtype, fn, 6 + n, 0, 0);
    else
        run_instr(op_rtype, fn, 0, 6 + n, 0);
    expect_common();
    exp_strobes[5][start]            = 1'b1;
    exp_strobes[7 + n][sb_hilo_load] = 1'b1;
    check_run(7 + n);
    compare_strobe("hilo_sel in HI/LO load", sel, sel_log[7 + n]);
endtask

task automatic test_mult();
    check_muldiv(fn_mult, sb_mult_start, 1'b1);
    check_muldiv(fn_mult, sb_mult_start, 1'b1);
endtask

task automatic test_div();
    check_muldiv(fn_div, sb_div_start, 1'b0);
    check_muldiv(fn_div, sb_div_start, 1'b0);
endtask

// base is the EPC load cycle
task automatic check_exception(input int base, input mem_addr_t vec);
    exp_strobes[base][sb_epc_load]     = 1'b1;
    exp_strobes[base + 3][sb_mdr_load] = 1'b1;
    exp_strobes[base + 4][sb_pc_write] = 1'b1;
    check_run(base + 4);
    compare_alu_op("alu_op in EPC load", alu_sub, alu_log[base]);
    compare_strobe("alu_src_a in EPC load", 1'b0, srca_log[base]);
    compare_src_b("alu_src_b in EPC load", src_b_four, src_b_log[base]);
    compare_mem_addr("mem_addr in vector read", vec, addr_log[base + 1]);
    compare_pc_src("pc_source in vector load", pc_mdr_vector, pc_log[base + 4]);
endtask

task automatic test_div_zero();
    int n;
    n = $unsigned($random(seed)) % 16;
    run_instr(op_rtype, fn_div, 0, 6 + n, 6 + n); // Done in the same cycle, zero wins
    expect_common();
    exp_strobes[5][sb_div_start] = 1'b1;
    check_exception(7 + n, addr_vec_divzero);
endtask

task automatic test_illegal();
    run_instr(6'h3f, 6'h00, 0, 0, 0); // Unknown opcode
    expect_common();
    check_exception(5, addr_vec_illegal);
    run_instr(op_rtype, 6'h3f, 0, 0, 0); // Unknown funct
    expect_common();
    check_exception(5, addr_vec_illegal);
endtask

// File: tb/mcu_ctrl_tb.sv
`include "mcu_ctrl_cfg.svh"

module mcu_ctrl_tb
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_tests  = 11;
    localparam int max_cycles = 60;

    // Bit positions in the recorded strobe vector
    typedef enum int {
        sb_pc_write, sb_pc_write_cond, sb_ir_load, sb_ab_load,
        sb_alu_out_load, sb_mem_write, sb_mdr_load, sb_reg_write,
        sb_hilo_load, sb_epc_load, sb_mult_start, sb_div_start
    } strobe_idx_t;

    string strobe_names [12] = '{
        "pc_write", "pc_write_cond", "ir_load", "ab_load",
        "alu_out_load", "mem_write", "mdr_load", "reg_write",
        "hilo_load", "epc_load", "mult_start", "div_start"
    };

    logic                    clk;
    logic                    reset;
    logic [`MCU_OP_W-1:0]    opcode;
    logic [`MCU_FUNCT_W-1:0] funct;
    logic                    div_zero;
    logic                    div_done;
    logic                    mult_done;
    alu_op_t                 alu_op;
    logic                    alu_src_a;
    alu_src_b_t              alu_src_b;
    pc_src_t                 pc_source;
    mem_addr_t               mem_addr;
    reg_dst_t                reg_dst;
    mem_to_reg_t             mem_to_reg;
    branch_op_t              branch_op;
    logic                    hilo_sel;
    logic                    pc_write;
    logic                    pc_write_cond;
    logic                    ir_load;
    logic                    ab_load;
    logic                    alu_out_load;
    logic                    mem_write;
    logic                    mdr_load;
    logic                    reg_write;
    logic                    hilo_load;
    logic                    epc_load;
    logic                    mult_start;
    logic                    div_start;

    // Per-cycle record of one instruction, index 1 is its fetch1
    logic [11:0] strobe_log [64];
    logic [11:0] exp_strobes [64];
    alu_op_t     alu_log [64];
    logic        srca_log [64];
    pc_src_t     pc_log [64];
    alu_src_b_t  src_b_log [64];
    mem_addr_t   addr_log [64];
    reg_dst_t    dst_log [64];
    mem_to_reg_t m2r_log [64];
    branch_op_t  br_log [64];
    logic        sel_log [64];
    int          run_len;
    integer      seed = 32'h11779f4b;
    bit          tests_done = 1'b0;

    mcu_ctrl_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        fail_run($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act));
    endtask

    task automatic compare_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_pc_src(input string name, input pc_src_t exp, input pc_src_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_strobe(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_src_b(input string name, input alu_src_b_t exp,
                                 input alu_src_b_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_mem_addr(input string name, input mem_addr_t exp,
                                    input mem_addr_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_reg_dst(input string name, input reg_dst_t exp, input reg_dst_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_mem_to_reg(input string name, input mem_to_reg_t exp,
                                      input mem_to_reg_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_branch_op(input string name, input branch_op_t exp,
                                     input branch_op_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp)
            report_mismatch(name, exp, act);
    endtask

    // Leaves the caller mid-cycle in fetch1
    task automatic reset_dut();
        @(negedge clk);
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic sample_outputs(input int c);
        strobe_log[c] = {div_start, mult_start, epc_load, hilo_load, reg_write, mdr_load,
                         mem_write, alu_out_load, ab_load, ir_load, pc_write_cond, pc_write};
        alu_log[c]    = alu_op;
        srca_log[c]   = alu_src_a;
        pc_log[c]     = pc_source;
        src_b_log[c]  = alu_src_b;
        addr_log[c]   = mem_addr;
        dst_log[c]    = reg_dst;
        m2r_log[c]    = mem_to_reg;
        br_log[c]     = branch_op;
        sel_log[c]    = hilo_sel;
    endtask

    // Flags are raised for the one cycle given, 0 means never
    task automatic run_instr(input logic [`MCU_OP_W-1:0] op, input logic [`MCU_FUNCT_W-1:0] fn,
                             input int mult_at, input int div_at, input int zero_at);
        int cycle;
        bit found;
        reset_dut();
        opcode = op;
        funct  = fn;
        cycle  = 1;
        found  = 1'b0;
        while (!found) begin
            sample_outputs(cycle);
            if (cycle > 2 && pc_write && pc_source == pc_alu_result && alu_op == alu_add) begin
                found = 1'b1; // fetch2 of the next instruction
            end else begin
                if (cycle == max_cycles) begin
                    fail_run("The instruction never returned to fetch");
                end
                mult_done = (cycle == mult_at);
                div_done  = (cycle == div_at);
                div_zero  = (cycle == zero_at);
                cycle++;
                @(negedge clk);
            end
        end
        mult_done = 1'b0;
        div_done  = 1'b0;
        div_zero  = 1'b0;
        run_len   = cycle - 2;
    endtask

    // Every strobe on every cycle, up to and including the next fetch1
    task automatic check_run(input int exp_len);
        int c;
        int i;
        compare_count("instruction length", exp_len, run_len);
        for (c = 1; c <= exp_len + 1; c++) begin
            for (i = 0; i < 12; i++) begin
                compare_strobe($sformatf("%s in cycle %0d", strobe_names[i], c),
                               exp_strobes[c][i], strobe_log[c][i]);
            end
        end
        compare_alu_op("alu_op in fetch2", alu_add, alu_log[2]);
        compare_strobe("alu_src_a in fetch2", 1'b0, srca_log[2]);
        compare_pc_src("pc_source in fetch2", pc_alu_result, pc_log[2]);
        compare_src_b("alu_src_b in fetch2", src_b_four, src_b_log[2]);
    endtask

    `include "mcu_ctrl_tests.svh"

    initial begin
        reset     = 1'b1;
        opcode    = '0;
        funct     = '0;
        div_zero  = 1'b0;
        div_done  = 1'b0;
        mult_done = 1'b0;
        test_reset();
        test_alu_r();
        test_addi();
        test_branch();
        test_jump();
        test_load();
        test_store();
        test_mult();
        test_div();
        test_div_zero();
        test_illegal();
        tests_done = 1'b1;
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (num_tests * 200) @(posedge clk);
        if (!tests_done) begin
            fail_run("Timeout: the tests did not finish within the cycle budget");
        end
    end

endmodule

// File: mcu_ctrl.f
+incdir+hdl
+incdir+tb
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/main_sequencer.sv
hdl/datapath_ctrl_encoder.sv
hdl/mcu_ctrl_top.sv
tb/mcu_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f mcu_ctrl.f --top-module mcu_ctrl_tb -o mcu_ctrl_sim

# The log is checked below, so a failing run must not stop the script here
./obj_dir/mcu_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation run passed"
else
    echo "Simulation run failed"
    exit 1
fi
